// ==== rtl/router_config.svh ====
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// number of router ports, in the order L, N, E, W, S.
`define NUM_PORTS 5

// packet length in flits, carried by the head flit.
`define LEN_W 12

// flit payload width.
`define DATA_W 32

// flit kind code width.
`define KIND_W 3

`endif

// ==== rtl/routerPkg.sv ====
`default_nettype none

`include "router_config.svh"

package routerPkg;

  // the head code matches the one the upstream routers already send.
  typedef enum logic [`KIND_W-1:0] {
    HEAD = 1,
    BODY = 2
  } flitKindT;

  typedef enum logic [2:0] {
    PORT_L = 0,
    PORT_N = 1,
    PORT_E = 2,
    PORT_W = 3,
    PORT_S = 4
  } portIdxT;

endpackage

`default_nettype wire

// ==== rtl/packetTimer.sv ====
`default_nettype none

`include "router_config.svh"

module packetTimer
(
  input  logic              clk,
  input  logic              rst,
  input  logic              load,
  input  logic [`LEN_W-1:0] loadLength,
  input  logic              step,
  output logic              last
);

  logic [`LEN_W-1:0] remaining;

  // counts the flits of the current packet that have not left the buffer yet.
  always_ff @(posedge clk)
  begin
    if (rst)
      remaining <= '0;
    else if (load)
      remaining <= loadLength;
    else if (step && (remaining != '0))
      remaining <= remaining - 1'b1;
  end

  assign last = (remaining == `LEN_W'(1));

endmodule

`default_nettype wire

// ==== rtl/inputChannel.sv ====
`default_nettype none

`include "router_config.svh"

module inputChannel
  import routerPkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               inReq,
  output logic               inAck,
  input  flitKindT           inKind,
  input  logic [`LEN_W-1:0]  inLength,
  input  logic [`DATA_W-1:0] inData,
  input  logic               chPop,
  output logic               chValid,
  output logic               chLast,
  output flitKindT           chKind,
  output logic [`LEN_W-1:0]  chLength,
  output logic [`DATA_W-1:0] chData
);

  logic capture;
  logic headCapture;

  // a full buffer holds off the ack, which stalls the upstream sender.
  assign capture = inReq && !inAck && !chValid;
  assign headCapture = capture && (inKind == HEAD);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck   <= 1'b0;
      chValid <= 1'b0;
    end
    else
    begin
      if (capture)
        inAck <= 1'b1;
      else if (!inReq)
        inAck <= 1'b0;

      if (capture)
        chValid <= 1'b1;
      else if (chPop)
        chValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      chKind   <= inKind;
      chLength <= inLength;
      chData   <= inData;
    end
  end

  packetTimer uTimer (
    .clk       (clk),
    .rst       (rst),
    .load      (headCapture),
    .loadLength(inLength),
    .step      (chPop),
    .last      (chLast)
  );

  // the link may only drain a channel that holds a flit.
  assert property (@(posedge clk) disable iff (rst) chPop |-> chValid)
    else $error("pop of an empty input channel");

endmodule

`default_nettype wire

// ==== rtl/switchArbiter.sv ====
`default_nettype none

`include "router_config.svh"

module switchArbiter
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] chValid,
  input  logic [`NUM_PORTS-1:0] chPop,
  input  logic [`NUM_PORTS-1:0] chLast,
  output logic [`NUM_PORTS-1:0] grant,
  output logic                  grantValid
);

  portIdxT               current;
  portIdxT               winner;
  logic                  found;
  logic                  packetDone;
  logic [`NUM_PORTS-1:0] candidates;

  // a channel popped in this cycle is empty afterwards and does not compete.
  assign candidates = chValid & ~chPop;
  assign packetDone = |(chPop & chLast & grant);

  // from idle the search starts at L, otherwise at the port after the one served.
  always_comb
  begin : search
    int start;
    int idx;
    start = 0;
    if (grantValid)
      start = (int'(current) + 1) % `NUM_PORTS;
    winner = current;
    found  = 1'b0;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      idx = (start + k) % `NUM_PORTS;
      if (!found && candidates[idx])
      begin
        found  = 1'b1;
        winner = portIdxT'(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantValid <= 1'b0;
      current    <= PORT_L;
    end
    else if (!grantValid || packetDone)
    begin
      grantValid <= found;
      if (found)
        current <= winner;
    end
  end

  assign grant = grantValid ? (`NUM_PORTS'(1) << current) : '0;

  assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant != '0) == grantValid))
    else $error("grant is not zero-or-one-hot or disagrees with grantValid");

endmodule

`default_nettype wire

// ==== rtl/outputLink.sv ====
`default_nettype none

`include "router_config.svh"

module outputLink
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] grant,
  input  logic                  grantValid,
  input  logic [`NUM_PORTS-1:0] chValid,
  input  logic [`NUM_PORTS-1:0] chLast,
  input  flitKindT              chKind [`NUM_PORTS],
  input  logic [`LEN_W-1:0]     chLength [`NUM_PORTS],
  input  logic [`DATA_W-1:0]    chData [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] chPop,
  output logic                  outReq,
  input  logic                  outAck,
  output logic [`DATA_W-1:0]    outData,
  output flitKindT              outKind,
  output logic [`LEN_W-1:0]     outLength,
  output portIdxT               outSrc
);

  typedef enum logic [1:0] {
    LINK_IDLE,
    LINK_SEND,
    LINK_RELEASE
  } linkStateT;

  linkStateT state;
  portIdxT   selIdx;
  logic      takeFlit;
  logic      packetOpen;

  always_comb
  begin
    selIdx = PORT_L;
    for (int i = 0; i < `NUM_PORTS; i++)
      if (grant[i])
        selIdx = portIdxT'(i);
  end

  assign takeFlit = (state == LINK_IDLE) && grantValid && |(grant & chValid);
  assign chPop = takeFlit ? grant : '0;
  assign outReq = (state == LINK_SEND);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= LINK_IDLE;
      packetOpen <= 1'b0;
    end
    else
    begin
      case (state)
        LINK_IDLE:    if (takeFlit) state <= LINK_SEND;
        LINK_SEND:    if (outAck) state <= LINK_RELEASE;
        LINK_RELEASE: if (!outAck) state <= LINK_IDLE;
        default:      state <= LINK_IDLE;
      endcase
      if (takeFlit)
        packetOpen <= !chLast[selIdx];
    end
  end

  always_ff @(posedge clk)
  begin
    if (takeFlit)
    begin
      outData   <= chData[selIdx];
      outKind   <= chKind[selIdx];
      outLength <= chLength[selIdx];
      outSrc    <= selIdx;
    end
  end

  // downstream may sample the flit at any point while the request is up.
  assert property (@(posedge clk) disable iff (rst)
    $past(outReq) && outReq |-> $stable(outData) && $stable(outKind)
                                && $stable(outLength) && $stable(outSrc))
    else $error("output flit changed while outReq was high");

  // a head only opens a packet and a body only continues one.
  assert property (@(posedge clk) disable iff (rst)
    takeFlit |-> ((chKind[selIdx] == HEAD) != packetOpen))
    else $error("flit kind does not fit the packet in progress");

endmodule

`default_nettype wire

// ==== rtl/routerOutputPort.sv ====
`default_nettype none

`include "router_config.svh"

module routerOutputPort
  import routerPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] inReq,
  output logic [`NUM_PORTS-1:0] inAck,
  input  flitKindT              inKind [`NUM_PORTS],
  input  logic [`LEN_W-1:0]     inLength [`NUM_PORTS],
  input  logic [`DATA_W-1:0]    inData [`NUM_PORTS],
  output logic                  outReq,
  input  logic                  outAck,
  output logic [`DATA_W-1:0]    outData,
  output flitKindT              outKind,
  output logic [`LEN_W-1:0]     outLength,
  output portIdxT               outSrc
);

  logic [`NUM_PORTS-1:0] chValid;
  logic [`NUM_PORTS-1:0] chLast;
  logic [`NUM_PORTS-1:0] chPop;
  flitKindT              chKind [`NUM_PORTS];
  logic [`LEN_W-1:0]     chLength [`NUM_PORTS];
  logic [`DATA_W-1:0]    chData [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] grant;
  logic                  grantValid;

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gChannel
    inputChannel uChannel (
      .clk     (clk),
      .rst     (rst),
      .inReq   (inReq[p]),
      .inAck   (inAck[p]),
      .inKind  (inKind[p]),
      .inLength(inLength[p]),
      .inData  (inData[p]),
      .chPop   (chPop[p]),
      .chValid (chValid[p]),
      .chLast  (chLast[p]),
      .chKind  (chKind[p]),
      .chLength(chLength[p]),
      .chData  (chData[p])
    );
  end

  switchArbiter uArbiter (
    .clk       (clk),
    .rst       (rst),
    .chValid   (chValid),
    .chPop     (chPop),
    .chLast    (chLast),
    .grant     (grant),
    .grantValid(grantValid)
  );

  outputLink uLink (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .grantValid(grantValid),
    .chValid   (chValid),
    .chLast    (chLast),
    .chKind    (chKind),
    .chLength  (chLength),
    .chData    (chData),
    .chPop     (chPop),
    .outReq    (outReq),
    .outAck    (outAck),
    .outData   (outData),
    .outKind   (outKind),
    .outLength (outLength),
    .outSrc    (outSrc)
  );

endmodule

`default_nettype wire

// ==== test/tbRouterOutputPort.sv ====
`default_nettype none

`include "router_config.svh"

module tbRouterOutputPort
  import routerPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FLIT_W = `KIND_W + `LEN_W + `DATA_W;

  logic                  clk;
  logic                  rst;
  logic [`NUM_PORTS-1:0] inReq;
  logic [`NUM_PORTS-1:0] inAck;
  flitKindT              inKind [`NUM_PORTS];
  logic [`LEN_W-1:0]     inLength [`NUM_PORTS];
  logic [`DATA_W-1:0]    inData [`NUM_PORTS];
  logic                  outReq;
  logic                  outAck;
  logic [`DATA_W-1:0]    outData;
  flitKindT              outKind;
  logic [`LEN_W-1:0]     outLength;
  portIdxT               outSrc;

  int                    seed;
  logic                  holdAck;
  int                    recvCount;
  int                    capturedTotal;
  logic [FLIT_W-1:0]     expQ [`NUM_PORTS][$];
  int                    headLog [$];

  routerOutputPort UUT (
    .clk      (clk),
    .rst      (rst),
    .inReq    (inReq),
    .inAck    (inAck),
    .inKind   (inKind),
    .inLength (inLength),
    .inData   (inData),
    .outReq   (outReq),
    .outAck   (outAck),
    .outData  (outData),
    .outKind  (outKind),
    .outLength(outLength),
    .outSrc   (outSrc)
  );

  always #5 clk = ~clk;

  task automatic stopWithFailure(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkValue(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp)
    else
      stopWithFailure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // the arbitration rule: L first from idle, else start after the last winner.
  function automatic int nextWinner(int last, logic [`NUM_PORTS-1:0] ready);
    int start;
    int idx;
    start = (last < 0) ? 0 : (last + 1) % `NUM_PORTS;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      idx = (start + k) % `NUM_PORTS;
      if (ready[idx])
        return idx;
    end
    return -1;
  endfunction

  function automatic int pendingFlits();
    int total;
    total = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
      total += expQ[p].size();
    return total;
  endfunction

  task automatic waitInAck(int p, logic level);
    int count = 0;
    while (inAck[p] !== level)
    begin
      @(negedge clk);
      count++;
      if (count > 5000)
        stopWithFailure($sformatf("port %0d timed out waiting for its ack", p));
    end
  endtask

  task automatic waitOutReq(logic level, int limit);
    int count = 0;
    while (outReq !== level)
    begin
      @(negedge clk);
      count++;
      if (count > limit)
        stopWithFailure("timed out waiting for the output request to change");
    end
  endtask

  task automatic sendFlit(int p, flitKindT kind, int len, logic [`DATA_W-1:0] data);
    expQ[p].push_back({kind, `LEN_W'(len), data});
    inKind[p] = kind;
    inLength[p] = `LEN_W'(len);
    inData[p] = data;
    inReq[p] = 1'b1;
    waitInAck(p, 1'b1);
    capturedTotal++;
    inReq[p] = 1'b0;
    waitInAck(p, 1'b0);
  endtask

  // a fixed length of zero picks random lengths and gaps.
  task automatic runPort(int p, int packets, int fixedLen);
    int len;
    for (int n = 0; n < packets; n++)
    begin
      len = (fixedLen > 0) ? fixedLen : 1 + ($unsigned($random(seed)) % 6);
      for (int f = 0; f < len; f++)
      begin
        sendFlit(p, (f == 0) ? HEAD : BODY, len, $random(seed));
        if (fixedLen == 0)
          repeat ($unsigned($random(seed)) % 4) @(negedge clk);
      end
    end
  endtask

  task automatic receiveFlits();
    logic [FLIT_W-1:0] expFlit;
    int src;
    int pktSrc;
    int pktLeft;
    int count;
    pktLeft = 0;
    pktSrc = 0;
    forever
    begin
      waitOutReq(1'b1, 2000);
      src = int'(outSrc);
      checkValue("outSrc in range", src < `NUM_PORTS, 1);
      checkValue("flits outstanding on outSrc", expQ[src].size() > 0, 1);
      expFlit = expQ[src].pop_front();
      checkValue("outKind", outKind, expFlit[FLIT_W-1 -: `KIND_W]);
      checkValue("outLength", outLength, expFlit[`LEN_W+`DATA_W-1 -: `LEN_W]);
      checkValue("outData", outData, expFlit[`DATA_W-1:0]);
      // wormhole check: body flits must continue the open packet.
      if (pktLeft > 0)
      begin
        checkValue("outSrc within packet", src, pktSrc);
        checkValue("outKind within packet", outKind, BODY);
        pktLeft--;
      end
      else
      begin
        checkValue("outKind at packet start", outKind, HEAD);
        pktSrc = src;
        pktLeft = int'(outLength) - 1;
        headLog.push_back(src);
      end
      recvCount++;
      repeat ($unsigned($random(seed)) % 4) @(negedge clk);
      count = 0;
      while (holdAck)
      begin
        @(negedge clk);
        count++;
        if (count > 1000)
          stopWithFailure("output ack was held back for too long");
      end
      outAck = 1'b1;
      waitOutReq(1'b0, 100);
      outAck = 1'b0;
    end
  endtask

  initial
  begin : mainFlow
    logic [`NUM_PORTS-1:0] ready;
    int last;
    int expSrc;
    int count;
    seed = 32'h7dd6;
    clk = 1'b0;
    rst = 1'b1;
    inReq = '0;
    outAck = 1'b0;
    holdAck = 1'b0;
    recvCount = 0;
    capturedTotal = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inKind[p] = HEAD;
      inLength[p] = '0;
      inData[p] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    checkValue("outReq", outReq, 0);
    checkValue("inAck", inAck, 0);
    fork
      receiveFlits();
    join_none

    // an L packet occupies the link so that N holds the grant while the others load.
    holdAck = 1'b1;
    sendFlit(0, HEAD, 1, 32'h0000_a000);
    waitOutReq(1'b1, 100);
    sendFlit(1, HEAD, 1, 32'h0000_a001);
    sendFlit(2, HEAD, 1, 32'h0000_a002);
    sendFlit(3, HEAD, 1, 32'h0000_a003);
    sendFlit(4, HEAD, 1, 32'h0000_a004);
    sendFlit(0, HEAD, 1, 32'h0000_a005);
    holdAck = 1'b0;
    count = 0;
    // the last directed flit has to leave the link before back-pressure starts.
    while (recvCount < 6 || outReq)
    begin
      @(negedge clk);
      count++;
      if (count > 500)
        stopWithFailure("directed rotation packets did not all arrive");
    end
    checkValue("outSrc of first head", headLog[0], nextWinner(-1, 5'b00001));
    checkValue("outSrc of second head", headLog[1], nextWinner(-1, 5'b00010));
    ready = 5'b11101;
    last = 1;
    for (int i = 2; i < 6; i++)
    begin
      expSrc = nextWinner(last, ready);
      checkValue("outSrc of rotated head", headLog[i], expSrc);
      ready[expSrc] = 1'b0;
      last = expSrc;
    end

    // back-pressure. five buffers plus the link register hold six flits.
    holdAck = 1'b1;
    capturedTotal = 0;
    fork
      runPort(0, 1, 3);
      runPort(1, 1, 3);
      runPort(2, 1, 3);
      runPort(3, 1, 3);
      runPort(4, 1, 3);
      begin
        repeat (200) @(negedge clk);
        checkValue("outReq", outReq, 1);
        checkValue("inReq", inReq, 5'h1f);
        checkValue("inAck", inAck, 0);
        checkValue("captured flits", capturedTotal, `NUM_PORTS + 1);
        holdAck = 1'b0;
      end
    join

    fork
      runPort(0, 40, 0);
      runPort(1, 40, 0);
      runPort(2, 40, 0);
      runPort(3, 40, 0);
      runPort(4, 40, 0);
    join
    count = 0;
    while (pendingFlits() != 0 || outReq)
    begin
      @(negedge clk);
      count++;
      if (count > 5000)
        stopWithFailure("queued flits were never delivered");
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/routerPkg.sv
rtl/packetTimer.sv
rtl/inputChannel.sv
rtl/switchArbiter.sv
rtl/outputLink.sv
rtl/routerOutputPort.sv
test/tbRouterOutputPort.sv

// ==== Bender.yml ====
package:
  name: router_output_port

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/routerPkg.sv
      - rtl/packetTimer.sv
      - rtl/inputChannel.sv
      - rtl/switchArbiter.sv
      - rtl/outputLink.sv
      - rtl/routerOutputPort.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tbRouterOutputPort.sv
